// ==== verilog/controlPkg.sv ====
package controlPkg;
	// Datapath widths
	localparam int DATA_WIDTH = 16;
	localparam int REG_COUNT = 8;
	localparam int OFFSET_WIDTH = 4;

	typedef logic [DATA_WIDTH-1:0] dataWord;
	typedef logic [$clog2(REG_COUNT)-1:0] regIndex;

	// Instruction phases, one cycle each
	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} phaseT;

	// Adder A operand
	typedef logic [1:0] aluaSel;
	localparam aluaSel ALUA_ZERO = 2'd0;
	localparam aluaSel ALUA_TWO = 2'd1;
	localparam aluaSel ALUA_MINUS_TWO = 2'd2;
	// Offset zero-extended and scaled to words
	localparam aluaSel ALUA_OFFSET = 2'd3;

	// Adder B operand
	typedef logic alubSel;
	localparam alubSel ALUB_ZERO = 1'b0;
	localparam alubSel ALUB_REG_B = 1'b1;

	// Memory address source
	typedef logic addrSel;
	localparam addrSel ADDR_REG_B = 1'b0;
	localparam addrSel ADDR_ALU = 1'b1;

	// Rb port address source
	typedef logic [1:0] regbAddrSel;
	localparam regbAddrSel REGB_ARGB = 2'd0;
	localparam regbAddrSel REGB_RFP = 2'd1;
	localparam regbAddrSel REGB_RSP = 2'd2;
	localparam regbAddrSel REGB_RRS = 2'd3;
endpackage

// ==== verilog/isaPkg.sv ====
package isaPkg;
	import controlPkg::*;

	// Instruction word and its fields
	typedef logic [15:0] instrWord;
	typedef logic [1:0] groupField;
	typedef logic [1:0] ldsOp;
	typedef logic [2:0] ldsMode;

	localparam groupField GROUP_LOAD_STORE = 2'd2;

	// Load/store op codes, 2 and 3 are no-ops
	localparam ldsOp LDSOP_LD = 2'd0;
	localparam ldsOp LDSOP_ST = 2'd1;

	// Addressing modes
	localparam ldsMode MODE_REG_REG = 3'd0;
	localparam ldsMode MODE_REG_DEC = 3'd1;
	localparam ldsMode MODE_REG_INC = 3'd2;
	localparam ldsMode MODE_HERE = 3'd3;
	localparam ldsMode MODE_FP = 3'd4;
	localparam ldsMode MODE_SP = 3'd5;
	localparam ldsMode MODE_RS = 3'd6;
	localparam ldsMode MODE_NOP = 3'd7;

	// Fixed base registers
	localparam regIndex REG_RS = 3'd5;
	localparam regIndex REG_FP = 3'd6;
	localparam regIndex REG_SP = 3'd7;

	// Field extraction, bit 13 and bit 7 are not looked at
	function automatic groupField instrGroup(input instrWord instr);
		return instr[15:14];
	endfunction

	function automatic ldsOp instrOp(input instrWord instr);
		return instr[12:11];
	endfunction

	function automatic ldsMode instrMode(input instrWord instr);
		return instr[10:8];
	endfunction

	function automatic regIndex instrRa(input instrWord instr);
		return instr[6:4];
	endfunction

	function automatic regIndex instrRb(input instrWord instr);
		return instr[2:0];
	endfunction

	function automatic logic [OFFSET_WIDTH-1:0] instrOffset(input instrWord instr);
		return instr[OFFSET_WIDTH-1:0];
	endfunction
endpackage

// ==== verilog/instructionPhaseDecoder.sv ====
`timescale 1ns/1ps

module instructionPhaseDecoder
	import controlPkg::*, isaPkg::*;
(
	input  logic     CLK,
	input  logic     rst,
	input  instrWord din,
	output logic     fetch,
	output logic     decode,
	output logic     execute,
	output logic     commit,
	output instrWord instruction
);

	phaseT phase;
	phaseT phaseNext;

	// Fixed four step cycle, no stalls
	always_comb begin
		case (phase)
			FETCH: phaseNext = DECODE;
			DECODE: phaseNext = EXECUTE;
			EXECUTE: phaseNext = COMMIT;
			default: phaseNext = FETCH;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			phase <= FETCH;
		end else begin
			phase <= phaseNext;
		end
	end

	// Instruction register, din taken at the edge ending FETCH
	always_ff @(posedge CLK) begin
		if (rst) begin
			instruction <= '0;
		end else if (phase == FETCH) begin
			instruction <= din;
		end
	end

	// One-hot phase levels
	assign fetch = (phase == FETCH);
	assign decode = (phase == DECODE);
	assign execute = (phase == EXECUTE);
	assign commit = (phase == COMMIT);

endmodule

// ==== verilog/loadStoreGroupDecoder.sv ====
`timescale 1ns/1ps

module loadStoreGroupDecoder
	import controlPkg::*, isaPkg::*;
(
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    decode,
	input  logic                    execute,
	input  logic                    commit,
	input  instrWord                instruction,
	input  dataWord                 memRdData,
	output logic                    regaEn,
	output logic                    regbEn,
	output logic                    regaWen,
	output logic                    regbWen,
	output aluaSel                  aluaSrc,
	output alubSel                  alubSrc,
	output addrSel                  addrBus,
	output regbAddrSel              regbAddr,
	output logic                    rd,
	output logic                    wr,
	output regIndex                 raIndex,
	output regIndex                 rbIndex,
	output logic [OFFSET_WIDTH-1:0] offset,
	output dataWord                 loadData
);

	ldsOp opField;
	ldsMode modeField;
	logic inGroup;
	logic modeOk;
	logic updatesRb;
	logic isLoad;
	logic isStore;
	logic doLoad;
	logic doStore;
	logic doUpdate;
	logic active;

	assign opField = instrOp(instruction);
	assign modeField = instrMode(instruction);
	assign inGroup = (instrGroup(instruction) == GROUP_LOAD_STORE);

	// Register indices and offset go straight through
	assign raIndex = instrRa(instruction);
	assign rbIndex = instrRb(instruction);
	assign offset = instrOffset(instruction);

	// Datapath selects per addressing mode
	always_comb begin
		aluaSrc = ALUA_ZERO;
		alubSrc = ALUB_ZERO;
		addrBus = ADDR_REG_B;
		regbAddr = REGB_ARGB;
		modeOk = 1'b1;
		updatesRb = 1'b0;
		case (modeField)
			MODE_REG_REG: begin
				// Address straight from Rb
				addrBus = ADDR_REG_B;
			end
			MODE_REG_DEC: begin
				aluaSrc = ALUA_MINUS_TWO;
				alubSrc = ALUB_REG_B;
				addrBus = ADDR_ALU;
				updatesRb = 1'b1;
			end
			MODE_REG_INC: begin
				// Old Rb on the bus, Rb + 2 written back
				aluaSrc = ALUA_TWO;
				alubSrc = ALUB_REG_B;
				updatesRb = 1'b1;
			end
			MODE_FP, MODE_SP, MODE_RS: begin
				aluaSrc = ALUA_OFFSET;
				alubSrc = ALUB_REG_B;
				addrBus = ADDR_ALU;
				if (modeField == MODE_FP) begin
					regbAddr = REGB_RFP;
				end else if (modeField == MODE_SP) begin
					regbAddr = REGB_RSP;
				end else begin
					regbAddr = REGB_RRS;
				end
			end
			MODE_HERE, MODE_NOP: begin
				// HERE belongs to the PC block
				modeOk = 1'b0;
			end
			default: begin
				modeOk = 1'b0;
			end
		endcase
	end

	assign isLoad = inGroup && modeOk && (opField == LDSOP_LD);
	assign isStore = inGroup && modeOk && (opField == LDSOP_ST);

	// Instruction class settled during DECODE
	always_ff @(posedge CLK) begin
		if (rst) begin
			doLoad <= 1'b0;
			doStore <= 1'b0;
			doUpdate <= 1'b0;
		end else if (decode) begin
			doLoad <= isLoad;
			doStore <= isStore;
			doUpdate <= (isLoad || isStore) && updatesRb;
		end
	end

	// Phase gating of enables and strobes
	assign active = execute || commit;
	assign regaEn = (doLoad || doStore) && active;
	assign regbEn = (doLoad || doStore) && active;
	assign rd = doLoad && execute;
	assign wr = doStore && execute;
	assign regaWen = doLoad && commit;
	assign regbWen = doUpdate && commit;

	// Load data captured at the edge ending EXECUTE
	always_ff @(posedge CLK) begin
		if (rd) begin
			loadData <= memRdData;
		end
	end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
	import controlPkg::*;
(
	input  logic    CLK,
	input  logic    rst,
	input  logic    regaEn,
	input  logic    regbEn,
	input  logic    regaWen,
	input  logic    regbWen,
	input  regIndex regaAddr,
	input  regIndex regbAddr,
	input  dataWord regaDin,
	input  dataWord regbDin,
	output dataWord regaDout,
	output dataWord regbDout
);

	dataWord regs [REG_COUNT];

	// Port A written last so it wins on a shared index
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (regbWen) begin
				regs[regbAddr] <= regbDin;
			end
			if (regaWen) begin
				regs[regaAddr] <= regaDin;
			end
		end
	end

	// Asynchronous reads, zero when the port is idle
	assign regaDout = regaEn ? regs[regaAddr] : '0;
	assign regbDout = regbEn ? regs[regbAddr] : '0;

endmodule

// ==== verilog/addressUnit.sv ====
`timescale 1ns/1ps

module addressUnit
	import controlPkg::*;
(
	input  aluaSel                  aluaSrc,
	input  alubSel                  alubSrc,
	input  addrSel                  addrBus,
	input  logic [OFFSET_WIDTH-1:0] offset,
	input  dataWord                 regaDout,
	input  dataWord                 regbDout,
	output dataWord                 aluResult,
	output dataWord                 memAddr,
	output dataWord                 memWrData
);

	dataWord aluA;
	dataWord aluB;
	dataWord scaledOffset;

	// Word offset to byte address
	assign scaledOffset = {{(DATA_WIDTH - OFFSET_WIDTH - 1){1'b0}}, offset, 1'b0};

	// A operand
	always_comb begin
		case (aluaSrc)
			ALUA_TWO: aluA = dataWord'(2);
			ALUA_MINUS_TWO: aluA = '1 << 1;
			ALUA_OFFSET: aluA = scaledOffset;
			default: aluA = '0;
		endcase
	end

	// B operand
	always_comb begin
		if (alubSrc == ALUB_REG_B) begin
			aluB = regbDout;
		end else begin
			aluB = '0;
		end
	end

	// Address adder, carry out dropped
	assign aluResult = aluA + aluB;

	// Bus address source
	always_comb begin
		if (addrBus == ADDR_ALU) begin
			memAddr = aluResult;
		end else begin
			memAddr = regbDout;
		end
	end

	// Store data always from Ra
	assign memWrData = regaDout;

endmodule

// ==== verilog/loadStoreCore.sv ====
`timescale 1ns/1ps

module loadStoreCore
	import controlPkg::*, isaPkg::*;
(
	input  logic     CLK,
	input  logic     rst,
	input  instrWord din,
	input  dataWord  memRdData,
	output logic     fetch,
	output logic     memRd,
	output logic     memWr,
	output dataWord  memAddr,
	output dataWord  memWrData
);

	logic decode;
	logic execute;
	logic commit;
	instrWord instruction;
	logic regaEn;
	logic regbEn;
	logic regaWen;
	logic regbWen;
	aluaSel aluaSrc;
	alubSel alubSrc;
	addrSel addrBus;
	regbAddrSel regbAddr;
	regIndex raIndex;
	regIndex rbIndex;
	regIndex regbIndex;
	logic [OFFSET_WIDTH-1:0] offset;
	dataWord loadData;
	dataWord regaDout;
	dataWord regbDout;
	dataWord aluResult;

	instructionPhaseDecoder i_instructionPhaseDecoder (
		.CLK(CLK),
		.rst(rst),
		.din(din),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.instruction(instruction)
	);

	loadStoreGroupDecoder i_loadStoreGroupDecoder (
		.CLK(CLK),
		.rst(rst),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.instruction(instruction),
		.memRdData(memRdData),
		.regaEn(regaEn),
		.regbEn(regbEn),
		.regaWen(regaWen),
		.regbWen(regbWen),
		.aluaSrc(aluaSrc),
		.alubSrc(alubSrc),
		.addrBus(addrBus),
		.regbAddr(regbAddr),
		.rd(memRd),
		.wr(memWr),
		.raIndex(raIndex),
		.rbIndex(rbIndex),
		.offset(offset),
		.loadData(loadData)
	);

	// Rb port steered to a base register in the offset modes
	always_comb begin
		case (regbAddr)
			REGB_RFP: regbIndex = REG_FP;
			REGB_RSP: regbIndex = REG_SP;
			REGB_RRS: regbIndex = REG_RS;
			default: regbIndex = rbIndex;
		endcase
	end

	registerFile i_registerFile (
		.CLK(CLK),
		.rst(rst),
		.regaEn(regaEn),
		.regbEn(regbEn),
		.regaWen(regaWen),
		.regbWen(regbWen),
		.regaAddr(raIndex),
		.regbAddr(regbIndex),
		.regaDin(loadData),
		.regbDin(aluResult),
		.regaDout(regaDout),
		.regbDout(regbDout)
	);

	addressUnit i_addressUnit (
		.aluaSrc(aluaSrc),
		.alubSrc(alubSrc),
		.addrBus(addrBus),
		.offset(offset),
		.regaDout(regaDout),
		.regbDout(regbDout),
		.aluResult(aluResult),
		.memAddr(memAddr),
		.memWrData(memWrData)
	);

endmodule

// ==== verif/loadStoreCore_assertions.sv ====
`timescale 1ns/1ps

module loadStoreCoreAssertions (
	input logic CLK,
	input logic rst,
	input logic fetch,
	input logic execute,
	input logic memRd,
	input logic memWr
);

	int failCount = 0;

	// One strobe at a time
	noReadWithWrite: assert property (@(posedge CLK) disable iff (rst) !(memRd && memWr))
	else begin
		failCount++;
		$error("memRd and memWr high in the same cycle");
	end

	strobesInExecute: assert property (@(posedge CLK) disable iff (rst)
		(memRd || memWr) |-> execute)
	else begin
		failCount++;
		$error("Memory strobe outside EXECUTE");
	end

	// Four cycles per instruction, no stalls
	fetchPeriod: assert property (@(posedge CLK) disable iff (rst)
		fetch |=> !fetch ##1 !fetch ##1 !fetch ##1 fetch)
	else begin
		failCount++;
		$error("fetch did not recur after four cycles");
	end

	quietAfterReset: assert property (@(posedge CLK) rst |=> (!memRd && !memWr))
	else begin
		failCount++;
		$error("Memory strobe right after reset");
	end

endmodule

bind loadStoreCore loadStoreCoreAssertions i_loadStoreCoreAssertions (
	.CLK(CLK),
	.rst(rst),
	.fetch(fetch),
	.execute(execute),
	.memRd(memRd),
	.memWr(memWr)
);

// ==== verif/loadStoreCoreTb.sv ====
`timescale 1ns/1ps

module loadStoreCoreTb
	import controlPkg::*, isaPkg::*;
();

	localparam int NUM_INSTR = 600;
	localparam int RESET_CYCLES = 16;
	localparam int CLK_PERIOD = 8;
	localparam int MEM_WORDS = 64;
	localparam int TIMEOUT_NS = CLK_PERIOD * (NUM_INSTR * 4 + RESET_CYCLES + 100);

	logic CLK;
	logic rst;
	instrWord din;
	dataWord memRdData;
	logic fetch;
	logic memRd;
	logic memWr;
	dataWord memAddr;
	dataWord memWrData;

	// Reference state
	dataWord memModel [MEM_WORDS];
	dataWord regModel [REG_COUNT];
	integer seed;
	int loadCount;
	int storeCount;
	int nopCount;

	loadStoreCore i_loadStoreCore (
		.CLK(CLK),
		.rst(rst),
		.din(din),
		.memRdData(memRdData),
		.fetch(fetch),
		.memRd(memRd),
		.memWr(memWr),
		.memAddr(memAddr),
		.memWrData(memWrData)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Run timed out before %0d instructions completed", NUM_INSTR);
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	end

	task automatic checkWord(input string name, input dataWord got, input dataWord exp);
		assert (got === exp) else begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Roughly three quarters land in the load/store group
	function automatic instrWord randomInstr();
		logic [31:0] r;
		instrWord instr;
		r = $random(seed);
		instr = r[15:0];
		if (r[17:16] != 2'b00) begin
			instr[15:14] = GROUP_LOAD_STORE;
			instr[13] = 1'b0;
			if (r[18]) begin
				instr[12] = 1'b0;
			end
		end
		return instr;
	endfunction

	// One instruction, entered at the falling edge inside FETCH
	task automatic executeOne();
		instrWord instr;
		logic [1:0] grp;
		ldsOp op;
		ldsMode mode;
		regIndex ra;
		regIndex rb;
		logic [3:0] off;
		logic isLoad;
		logic isStore;
		logic updRb;
		dataWord expAddr;
		dataWord newRb;
		dataWord loadVal;

		instr = randomInstr();
		grp = instr[15:14];
		op = instr[12:11];
		mode = instr[10:8];
		ra = instr[6:4];
		rb = instr[2:0];
		off = instr[3:0];
		isLoad = (grp == GROUP_LOAD_STORE) && (op == LDSOP_LD);
		isStore = (grp == GROUP_LOAD_STORE) && (op == LDSOP_ST);
		updRb = 1'b0;
		newRb = '0;
		loadVal = '0;
		expAddr = regModel[rb];
		case (mode)
			MODE_REG_REG: expAddr = regModel[rb];
			MODE_REG_DEC: begin
				expAddr = regModel[rb] - 16'd2;
				newRb = expAddr;
				updRb = 1'b1;
			end
			MODE_REG_INC: begin
				expAddr = regModel[rb];
				newRb = regModel[rb] + 16'd2;
				updRb = 1'b1;
			end
			MODE_FP: expAddr = regModel[REG_FP] + {11'd0, off, 1'b0};
			MODE_SP: expAddr = regModel[REG_SP] + {11'd0, off, 1'b0};
			MODE_RS: expAddr = regModel[REG_RS] + {11'd0, off, 1'b0};
			default: begin
				// HERE and mode 7 do nothing here
				isLoad = 1'b0;
				isStore = 1'b0;
			end
		endcase

		checkFlag("fetch", fetch, 1'b1);
		checkFlag("memRd", memRd, 1'b0);
		checkFlag("memWr", memWr, 1'b0);
		din = instr;
		memRdData = dataWord'($random(seed));

		@(negedge CLK);
		checkFlag("fetch", fetch, 1'b0);
		checkFlag("memRd", memRd, 1'b0);
		checkFlag("memWr", memWr, 1'b0);

		@(negedge CLK);
		checkFlag("fetch", fetch, 1'b0);
		checkFlag("memRd", memRd, isLoad);
		checkFlag("memWr", memWr, isStore);
		if (isLoad || isStore) begin
			checkWord("memAddr", memAddr, expAddr);
		end
		if (isStore) begin
			checkWord("memWrData", memWrData, regModel[ra]);
			memModel[expAddr[6:1]] = regModel[ra];
		end
		if (isLoad) begin
			loadVal = memModel[expAddr[6:1]];
			memRdData = loadVal;
		end else begin
			memRdData = dataWord'($random(seed));
		end

		@(negedge CLK);
		checkFlag("fetch", fetch, 1'b0);
		checkFlag("memRd", memRd, 1'b0);
		checkFlag("memWr", memWr, 1'b0);
		// Rb update first so a load into the same register wins
		if ((isLoad || isStore) && updRb) begin
			regModel[rb] = newRb;
		end
		if (isLoad) begin
			regModel[ra] = loadVal;
			loadCount++;
		end else if (isStore) begin
			storeCount++;
		end else begin
			nopCount++;
		end
	endtask

	initial begin
		seed = 32'h0a11_f0ca;
		rst = 1'b1;
		din = '0;
		memRdData = '0;
		loadCount = 0;
		storeCount = 0;
		nopCount = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			memModel[i] = dataWord'(16'hc3a5 ^ (i * 16'h0b17));
		end
		for (int i = 0; i < REG_COUNT; i++) begin
			regModel[i] = '0;
		end

		// Phase held at FETCH, strobes quiet during reset
		repeat (RESET_CYCLES) begin
			@(negedge CLK);
			checkFlag("fetch", fetch, 1'b1);
			checkFlag("memRd", memRd, 1'b0);
			checkFlag("memWr", memWr, 1'b0);
		end
		rst = 1'b0;

		for (int n = 0; n < NUM_INSTR; n++) begin
			executeOne();
			@(negedge CLK);
		end

		if (i_loadStoreCore.i_loadStoreCoreAssertions.failCount != 0) begin
			$display("Bound assertions failed %0d times",
				i_loadStoreCore.i_loadStoreCoreAssertions.failCount);
			$display("TEST FAILED");
			$fatal(1, "Assertion failures during the run");
		end else begin
			$display("Ran %0d instructions: %0d loads, %0d stores, %0d no-ops",
				NUM_INSTR, loadCount, storeCount, nopCount);
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
verilog/controlPkg.sv
verilog/isaPkg.sv
verilog/instructionPhaseDecoder.sv
verilog/loadStoreGroupDecoder.sv
verilog/registerFile.sv
verilog/addressUnit.sv
verilog/loadStoreCore.sv
verif/loadStoreCore_assertions.sv
verif/loadStoreCoreTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module loadStoreCoreTb -Mdir obj_dir -o simv -f sim.f
	./obj_dir/simv +verilator+error+limit+1000 | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
